//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - rtl

sources:
  - target: rtl
    include_dirs:
      - rtl
    files:
      - rtl/lsu_pkg.sv
      - rtl/lsu_req_gen.sv
      - rtl/lsu_trans_ctrl.sv
      - rtl/lsu_resp_align.sv
      - rtl/lsu_top.sv
  - target: test
    files:
      - test/lsu_obi_mem.sv
      - test/lsu_tb.sv

//--- filelist.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_req_gen.sv
rtl/lsu_trans_ctrl.sv
rtl/lsu_resp_align.sv
rtl/lsu_top.sv
test/lsu_obi_mem.sv
test/lsu_tb.sv

//--- rtl/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

//////////////////////////////////////////////////
// bus geometry
//////////////////////////////////////////////////

// byte addressed, 32-bit data bus
`define LSU_ADDR_W 32 // address width
`define LSU_DATA_W 32 // data width
`define LSU_BE_W   4  // one enable per byte lane

//////////////////////////////////////////////////
// transaction control
//////////////////////////////////////////////////

// max accesses granted but not yet answered
// cnt_t must be able to hold this value
`define LSU_DEPTH  2

`endif

//--- rtl/lsu_pkg.sv
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

  // plain vectors for bus fields
  typedef logic [`LSU_ADDR_W-1:0] addr_t;    // byte address
  typedef logic [`LSU_DATA_W-1:0] data_t;    // data word
  typedef logic [`LSU_BE_W-1:0]   be_t;      // byte enables
  typedef logic [1:0]             byte_off_t; // byte within word
  typedef logic [1:0]             cnt_t;      // outstanding count, 0..LSU_DEPTH

  // access size from the decoder, code 3 also means byte
  typedef enum logic [1:0] {
    ACC_WORD = 2'd0,
    ACC_HALF = 2'd1,
    ACC_BYTE = 2'd2
  } access_type_e;

  // how a narrow load fills the upper bits, code 3 is treated as sign
  typedef enum logic [1:0] {
    EXT_ZERO = 2'd0,
    EXT_SIGN = 2'd1,
    EXT_ONES = 2'd2
  } ext_mode_e;

endpackage

`default_nettype wire

//--- rtl/lsu_req_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_req_gen
(
  input  lsu_pkg::addr_t        operand_a_ex_i,       // base from register file
  input  lsu_pkg::addr_t        operand_b_ex_i,       // offset or immediate
  input  logic                  addr_useincr_ex_i,    // 1: a + b, 0: a only
  input  lsu_pkg::access_type_e data_type_ex_i,       // word / half / byte
  input  lsu_pkg::data_t        data_wdata_ex_i,      // store data as held in the register
  input  lsu_pkg::byte_off_t    data_reg_offset_ex_i, // byte position inside the register
  input  logic                  data_req_ex_i,        // ex stage wants an access
  input  logic                  data_misaligned_ex_i, // second phase of a split access
  input  logic                  data_we_ex_i,         // store when high

  output lsu_pkg::addr_t        data_addr_o,          // bus address
  output lsu_pkg::be_t          data_be_o,            // bus byte enables
  output lsu_pkg::data_t        data_wdata_o,         // lane-aligned store data
  output logic                  data_we_o,            // bus write enable
  output lsu_pkg::byte_off_t    rdata_offset_o,       // offset for read alignment
  output logic                  data_misaligned_o     // first phase needs a second access
);

  lsu_pkg::addr_t     addr_int;  // effective address before word alignment
  lsu_pkg::byte_off_t addr_off;  // low two address bits
  lsu_pkg::byte_off_t wdata_off; // rotation amount in bytes

  //////////////////////////////////////////////////
  // address
  //////////////////////////////////////////////////

  assign addr_int = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign addr_off = addr_int[1:0];

  // second phase always starts at lane 0 of the next word
  assign data_addr_o    = data_misaligned_ex_i ? (addr_int & ~lsu_pkg::addr_t'(2'b11)) : addr_int;
  assign data_we_o      = data_we_ex_i;
  assign rdata_offset_o = addr_off;

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb
  begin
    case (data_type_ex_i)
      lsu_pkg::ACC_WORD:
      begin
        if (!data_misaligned_ex_i)
          data_be_o = lsu_pkg::be_t'(4'b1111) << addr_off; // offset upward
        else
        begin
          case (addr_off) // leftover low lanes
            2'b00:   data_be_o = 4'b0000; // never split, kept for completeness
            2'b01:   data_be_o = 4'b0001;
            2'b10:   data_be_o = 4'b0011;
            default: data_be_o = 4'b0111;
          endcase
        end
      end
      lsu_pkg::ACC_HALF:
      begin
        if (!data_misaligned_ex_i)
          data_be_o = lsu_pkg::be_t'(4'b0011) << addr_off; // offset 3 keeps only lane 3
        else
          data_be_o = 4'b0001; // upper byte of a half at offset 3
      end
      default:
        data_be_o = lsu_pkg::be_t'(4'b0001) << addr_off; // single lane
    endcase
  end

  // rotate store data so register byte reg_off lands on lane addr_off
  assign wdata_off = addr_off - data_reg_offset_ex_i;

  always_comb
  begin
    case (wdata_off)
      2'b00:   data_wdata_o = data_wdata_ex_i;
      2'b01:   data_wdata_o = {data_wdata_ex_i[23:0], data_wdata_ex_i[31:24]};
      2'b10:   data_wdata_o = {data_wdata_ex_i[15:0], data_wdata_ex_i[31:16]};
      default: data_wdata_o = {data_wdata_ex_i[7:0],  data_wdata_ex_i[31:8]};
    endcase
  end

  // split detection, only on a first phase
  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i)
    begin
      case (data_type_ex_i)
        lsu_pkg::ACC_WORD: data_misaligned_o = (addr_off != 2'b00);
        lsu_pkg::ACC_HALF: data_misaligned_o = (addr_off == 2'b11);
        default:           data_misaligned_o = 1'b0; // bytes never cross
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/lsu_resp_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_resp_align
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  ctrl_update_i,        // capture ex controls into wb
  input  lsu_pkg::access_type_e data_type_ex_i,
  input  lsu_pkg::ext_mode_e    data_sign_ext_ex_i,
  input  logic                  data_we_ex_i,
  input  lsu_pkg::byte_off_t    rdata_offset_i,       // address offset from request side
  input  logic                  data_misaligned_ex_i, // second phase sits in ex
  input  logic                  data_misaligned_i,    // first phase sits in ex
  input  logic                  data_rvalid_i,
  input  lsu_pkg::data_t        data_rdata_i,         // raw bus word

  output lsu_pkg::data_t        data_rdata_ex_o       // aligned, extended load result
);

  // wb copy of the access in flight
  lsu_pkg::access_type_e data_type_q;
  lsu_pkg::byte_off_t    rdata_offset_q;
  lsu_pkg::ext_mode_e    data_sign_ext_q;
  logic                  data_we_q;

  lsu_pkg::data_t rdata_q;   // first-phase word or last result
  lsu_pkg::data_t rdata_w;   // word, possibly assembled
  logic [15:0]    rdata_h;   // selected halfword
  logic [7:0]     rdata_b;   // selected byte
  logic           h_fill;    // fill bit above a half
  logic           b_fill;    // fill bit above a byte
  lsu_pkg::data_t rdata_ext; // final value for the register file

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_type_q     <= lsu_pkg::ACC_WORD;
      rdata_offset_q  <= '0;
      data_sign_ext_q <= lsu_pkg::EXT_ZERO;
      data_we_q       <= 1'b0;
    end
    else if (ctrl_update_i) // access granted, now waiting on rvalid
    begin
      data_type_q     <= data_type_ex_i;
      rdata_offset_q  <= rdata_offset_i;
      data_sign_ext_q <= data_sign_ext_ex_i;
      data_we_q       <= data_we_ex_i;
    end
  end

  //////////////////////////////////////////////////
  // lane select and misaligned assembly
  //////////////////////////////////////////////////

  // upper bytes of a split word come from the first response in rdata_q
  always_comb
  begin
    case (rdata_offset_q)
      2'b00:   rdata_w = data_rdata_i;
      2'b01:   rdata_w = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (rdata_offset_q)
      2'b00:   rdata_h = data_rdata_i[15:0];
      2'b01:   rdata_h = data_rdata_i[23:8];
      2'b10:   rdata_h = data_rdata_i[31:16];
      default: rdata_h = {data_rdata_i[7:0], rdata_q[31:24]}; // half across the word edge
    endcase
  end

  assign rdata_b = data_rdata_i[8*rdata_offset_q +: 8];

  // extension
  always_comb
  begin
    case (data_sign_ext_q)
      lsu_pkg::EXT_ZERO:
      begin
        h_fill = 1'b0;
        b_fill = 1'b0;
      end
      lsu_pkg::EXT_ONES:
      begin
        h_fill = 1'b1;
        b_fill = 1'b1;
      end
      default: // sign, also code 3
      begin
        h_fill = rdata_h[15];
        b_fill = rdata_b[7];
      end
    endcase
  end

  always_comb
  begin
    case (data_type_q)
      lsu_pkg::ACC_WORD: rdata_ext = rdata_w;
      lsu_pkg::ACC_HALF: rdata_ext = {{16{h_fill}}, rdata_h};
      default:           rdata_ext = {{24{b_fill}}, rdata_b};
    endcase
  end

  // raw word kept while a split load is half done, else the final value
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (data_rvalid_i && !data_we_q)
    begin
      if (data_misaligned_ex_i || data_misaligned_i)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q; // hold after rvalid

  a_rdata_known: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i && !data_we_q |-> !$isunknown(data_rdata_ex_o));

endmodule

`default_nettype wire

//--- rtl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
(
  input  logic                  clk,
  input  logic                  rst_n,

  // data bus
  output logic                  data_req_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  output lsu_pkg::addr_t        data_addr_o,
  output logic                  data_we_o,
  output lsu_pkg::be_t          data_be_o,
  output lsu_pkg::data_t        data_wdata_o,
  input  lsu_pkg::data_t        data_rdata_i,

  // execute stage
  input  logic                  data_we_ex_i,
  input  lsu_pkg::access_type_e data_type_ex_i,
  input  lsu_pkg::data_t        data_wdata_ex_i,
  input  lsu_pkg::byte_off_t    data_reg_offset_ex_i,
  input  lsu_pkg::ext_mode_e    data_sign_ext_ex_i,
  output lsu_pkg::data_t        data_rdata_ex_o,
  input  logic                  data_req_ex_i,
  input  lsu_pkg::addr_t        operand_a_ex_i,
  input  lsu_pkg::addr_t        operand_b_ex_i,
  input  logic                  addr_useincr_ex_i,

  // controller
  input  logic                  data_misaligned_ex_i, // second phase being issued
  output logic                  data_misaligned_o,    // re-issue needed

  output logic                  lsu_ready_ex_o,
  output logic                  lsu_ready_wb_o,
  output logic                  busy_o
);

  lsu_pkg::byte_off_t rdata_offset; // request offset to the wb alignment
  logic               ctrl_update;  // ex to wb handover

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  lsu_req_gen u_req_gen (
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .data_req_ex_i        (data_req_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .data_addr_o          (data_addr_o),
    .data_be_o            (data_be_o),
    .data_wdata_o         (data_wdata_o),
    .data_we_o            (data_we_o),
    .rdata_offset_o       (rdata_offset),
    .data_misaligned_o    (data_misaligned_o)
  );

  lsu_trans_ctrl u_trans_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .ctrl_update_o  (ctrl_update),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  // response side
  lsu_resp_align u_resp_align (
    .clk                  (clk),
    .rst_n                (rst_n),
    .ctrl_update_i        (ctrl_update),
    .data_type_ex_i       (data_type_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .rdata_offset_i       (rdata_offset),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .data_rvalid_i        (data_rvalid_i),
    .data_rdata_i         (data_rdata_i),
    .data_rdata_ex_o      (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

//--- rtl/lsu_trans_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_trans_ctrl
(
  input  logic clk,
  input  logic rst_n,

  input  logic data_req_ex_i,  // ex stage holds a request
  input  logic data_gnt_i,     // bus accepted the request
  input  logic data_rvalid_i,  // bus returned one response

  output logic data_req_o,     // bus request strobe
  output logic ctrl_update_o,  // ex access moves to wb this cycle
  output logic lsu_ready_ex_o, // ex stage may advance
  output logic lsu_ready_wb_o, // wb stage may advance
  output logic busy_o          // accesses in flight or pending
);

  localparam lsu_pkg::cnt_t DEPTH = lsu_pkg::cnt_t'(`LSU_DEPTH);

  lsu_pkg::cnt_t cnt_q;      // granted but unanswered
  lsu_pkg::cnt_t cnt_d;
  logic          count_up;   // request accepted
  logic          count_down; // response seen

  // no path from rvalid to req, only the registered count gates it
  assign data_req_o = data_req_ex_i && (cnt_q < DEPTH);

  assign count_up   = data_req_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  //////////////////////////////////////////////////
  // ready / busy
  //////////////////////////////////////////////////

  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i; // empty wb or its answer arrives

  // ex and wb advance in lock step once wb is occupied
  always_comb
  begin
    if (!data_req_ex_i)
      lsu_ready_ex_o = 1'b1;
    else if (cnt_q == 2'd0)
      lsu_ready_ex_o = count_up;
    else if (cnt_q == 2'd1)
      lsu_ready_ex_o = count_up && data_rvalid_i;
    else
      lsu_ready_ex_o = data_rvalid_i; // full, wait for the oldest to drain
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;
  assign busy_o        = (cnt_q != '0) || data_req_o;

  // outstanding counter
  always_comb
  begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q; // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= DEPTH);

  // bus may only answer what it granted
  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0));

  // full counter holds until a response drains it
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q == DEPTH) && !data_rvalid_i |=> (cnt_q == DEPTH));

endmodule

`default_nettype wire

//--- test/lsu_obi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_obi_mem
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req_i,
  input  lsu_pkg::addr_t addr_i,
  input  logic           we_i,
  input  lsu_pkg::be_t   be_i,
  input  lsu_pkg::data_t wdata_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output lsu_pkg::data_t rdata_o
);

  lsu_pkg::data_t mem [0:255]; // 1 KiB word indexed
  lsu_pkg::data_t rsp_data_q[$]; // responses in grant order
  int             rsp_due_q[$];  // cycle at which each may be returned
  int             cyc;
  int             delay;
  integer         seed;

  initial
  begin
    seed = 32'he66a;
    for (int i = 0; i < 256; i++)
      mem[i] = (i * 32'h0100_0193) ^ 32'hc3a5_5a3c; // pattern over the whole index
  end

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      cyc = 0;
      rsp_data_q.delete();
      rsp_due_q.delete();
    end
    else
    begin
      cyc = cyc + 1;
      if (req_i && gnt_o) // accepted this edge
      begin
        if (we_i)
          for (int l = 0; l < 4; l++)
            if (be_i[l])
              mem[addr_i[9:2]][8*l +: 8] = wdata_i[8*l +: 8]; // enabled lanes only
        delay = 1 + ($unsigned($random(seed)) % 3); // 1..3 cycles
        rsp_data_q.push_back(mem[addr_i[9:2]]);
        rsp_due_q.push_back(cyc + delay - 1);
      end
      rvalid_o <= 1'b0;
      if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc)
      begin
        rvalid_o <= 1'b1;
        rdata_o  <= rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
      end
      // random stalls
      gnt_o <= (($random(seed) & 3) != 0);
    end
  end

endmodule

`default_nettype wire

//--- test/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  localparam int N_ACCESS = 80;
  localparam int TIMEOUT  = 200 * N_ACCESS; // cycles

  logic clk, rst_n;
  logic data_req, data_gnt, data_rvalid, data_we, data_we_ex, data_req_ex;
  logic addr_useincr_ex, data_misaligned_ex, data_misaligned;
  logic lsu_ready_ex, lsu_ready_wb, busy;
  lsu_pkg::addr_t        data_addr, operand_a_ex, operand_b_ex;
  lsu_pkg::be_t          data_be;
  lsu_pkg::data_t        data_wdata, data_rdata, data_wdata_ex, data_rdata_ex;
  lsu_pkg::access_type_e data_type_ex;
  lsu_pkg::byte_off_t    data_reg_offset_ex;
  lsu_pkg::ext_mode_e    data_sign_ext_ex;

  logic [7:0]  mirror [0:1023]; // reference memory, byte addressed
  logic [32:0] exp_q[$];        // {check, value} per bus response
  logic [32:0] rsp_entry;
  int          errors, checks, cycles, outst;
  logic        incr_sel;
  integer      seed;

  lsu_top DUT (
    .clk(clk), .rst_n(rst_n),
    .data_req_o(data_req), .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid),
    .data_addr_o(data_addr), .data_we_o(data_we), .data_be_o(data_be),
    .data_wdata_o(data_wdata), .data_rdata_i(data_rdata),
    .data_we_ex_i(data_we_ex), .data_type_ex_i(data_type_ex),
    .data_wdata_ex_i(data_wdata_ex), .data_reg_offset_ex_i(data_reg_offset_ex),
    .data_sign_ext_ex_i(data_sign_ext_ex), .data_rdata_ex_o(data_rdata_ex),
    .data_req_ex_i(data_req_ex), .operand_a_ex_i(operand_a_ex),
    .operand_b_ex_i(operand_b_ex), .addr_useincr_ex_i(addr_useincr_ex),
    .data_misaligned_ex_i(data_misaligned_ex), .data_misaligned_o(data_misaligned),
    .lsu_ready_ex_o(lsu_ready_ex), .lsu_ready_wb_o(lsu_ready_wb), .busy_o(busy)
  );

  lsu_obi_mem u_mem (
    .clk(clk), .rst_n(rst_n), .req_i(data_req), .addr_i(data_addr), .we_i(data_we),
    .be_i(data_be), .wdata_i(data_wdata), .gnt_o(data_gnt), .rvalid_o(data_rvalid),
    .rdata_o(data_rdata)
  );

  //////////////////////////////////////////////////
  // clock, reset, timeout
  //////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > TIMEOUT)
    begin
      $display("timeout: traffic did not complete within %0d cycles", TIMEOUT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // bus accesses granted but not yet answered
  always @(posedge clk or negedge rst_n)
    if (!rst_n)
      outst <= 0;
    else
      outst <= outst + int'(data_req && data_gnt) - int'(data_rvalid);

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("FAILED %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    data_req && !data_gnt |=> data_req && $stable(data_addr))
  else
  begin
    errors++;
    $display("FAILED %0t data_req_o/data_addr_o changed while stalled", $time);
  end

  a_ex_stall: assert property (@(posedge clk) disable iff (!rst_n)
    data_req && !data_gnt |-> !lsu_ready_ex)
  else
  begin
    errors++;
    $display("FAILED %0t lsu_ready_ex_o expected 0 got 1", $time);
  end

  a_depth: assert property (@(posedge clk) disable iff (!rst_n) outst <= 2)
  else
  begin
    errors++;
    $display("more than two accesses outstanding at %0t", $time);
  end

  a_busy: assert property (@(posedge clk) disable iff (!rst_n) outst != 0 |-> busy)
  else
  begin
    errors++;
    $display("FAILED %0t busy_o expected 1 got 0", $time);
  end

  // responses checked in order at the falling edge
  always @(negedge clk)
  begin
    if (rst_n)
      check_value("lsu_ready_wb_o", (outst == 0) || data_rvalid, lsu_ready_wb); // wb free or answered
    if (rst_n && data_rvalid)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("bus response with no access pending at %0t", $time);
      end
      else
      begin
        rsp_entry = exp_q.pop_front();
        if (rsp_entry[32])
          check_value("data_rdata_ex_o", rsp_entry[31:0], data_rdata_ex);
      end
    end
  end

  //////////////////////////////////////////////////
  // reference model from the access rules
  //////////////////////////////////////////////////

  function automatic logic [31:0] load_value(input lsu_pkg::access_type_e t,
                                             input lsu_pkg::ext_mode_e e, input int a);
    logic [31:0] w;
    logic        fill;
    w = {mirror[a+3], mirror[a+2], mirror[a+1], mirror[a]}; // little endian
    if (t == lsu_pkg::ACC_WORD)
      return w;
    fill = (e == lsu_pkg::EXT_ZERO) ? 1'b0 : (e == lsu_pkg::EXT_ONES) ? 1'b1 :
           (t == lsu_pkg::ACC_HALF) ? w[15] : w[7];
    if (t == lsu_pkg::ACC_HALF)
      return {{16{fill}}, w[15:0]};
    return {{24{fill}}, w[7:0]};
  endfunction

  function automatic logic [31:0] rotate_bytes(input logic [31:0] w, input logic [1:0] k);
    logic [63:0] tmp;
    tmp = {w, w} << (8 * k); // rotate left by k bytes
    return tmp[63:32];
  endfunction

  task automatic wait_ready();
    @(negedge clk);
    while (!lsu_ready_ex)
      @(negedge clk);
  endtask

  // one access as the execute stage issues it, second phase included when split
  task automatic do_access(input logic we, input lsu_pkg::access_type_e t,
                           input lsu_pkg::ext_mode_e e, input int addr,
                           input logic [31:0] wd, input logic [1:0] reg_off);
    logic [1:0] off;
    logic       mis_exp;
    int         size;
    off     = addr[1:0];
    size    = (t == lsu_pkg::ACC_WORD) ? 4 : (t == lsu_pkg::ACC_HALF) ? 2 : 1;
    mis_exp = (t == lsu_pkg::ACC_WORD && off != 0) || (t == lsu_pkg::ACC_HALF && off == 3);
    @(posedge clk);
    data_req_ex        <= 1'b1;
    data_we_ex         <= we;
    data_type_ex       <= t;
    data_sign_ext_ex   <= e;
    data_wdata_ex      <= wd;
    data_reg_offset_ex <= reg_off;
    data_misaligned_ex <= 1'b0;
    addr_useincr_ex    <= incr_sel; // alternate a+b and a only
    operand_a_ex       <= incr_sel ? (addr & ~32'hf) : addr;
    operand_b_ex       <= incr_sel ? (addr & 32'hf) : $random(seed);
    incr_sel = ~incr_sel;
    wait_ready();
    check_value("data_misaligned_o", mis_exp, data_misaligned);
    check_value("data_we_o", we, data_we);
    if (we)
    begin
      check_value("data_be_o", (32'hf >> (4 - size)) << off & 32'hf, data_be);
      check_value("data_wdata_o", rotate_bytes(wd, off - reg_off), data_wdata);
      for (int i = 0; i < size; i++)
        mirror[addr+i] = wd[8*((reg_off+i) % 4) +: 8];
    end
    if (mis_exp)
    begin
      exp_q.push_back({1'b0, 32'h0}); // first word, raw for a load
      @(posedge clk);
      addr_useincr_ex    <= 1'b0;
      operand_a_ex       <= addr + 4;
      data_misaligned_ex <= 1'b1;
      wait_ready();
      check_value("data_misaligned_o", 0, data_misaligned);
      check_value("data_addr_o", (addr + 4) & ~32'h3, data_addr);
      if (we)
      begin
        check_value("data_be_o", (32'hf >> (4 - size)) << off >> 4, data_be); // spilled lanes
        check_value("data_wdata_o", rotate_bytes(wd, off - reg_off), data_wdata);
      end
    end
    if (we)
      exp_q.push_back({1'b0, 32'h0});
    else
      exp_q.push_back({1'b1, load_value(t, e, addr)});
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] w;
    lsu_pkg::access_type_e t;
    int          a;
    seed               = 32'he66a;
    errors             = 0;
    checks             = 0;
    cycles             = 0;
    incr_sel           = 1'b0;
    rst_n              = 1'b0;
    data_req_ex        = 1'b0;
    data_we_ex         = 1'b0;
    data_type_ex       = lsu_pkg::ACC_WORD;
    data_wdata_ex      = '0;
    data_reg_offset_ex = '0;
    data_sign_ext_ex   = lsu_pkg::EXT_ZERO;
    operand_a_ex       = '0;
    operand_b_ex       = '0;
    addr_useincr_ex    = 1'b0;
    data_misaligned_ex = 1'b0;
    for (int i = 0; i < 256; i++)
    begin
      w = (i * 32'h0100_0193) ^ 32'hc3a5_5a3c; // same fill as the bus memory
      for (int j = 0; j < 4; j++)
        mirror[4*i+j] = w[8*j +: 8];
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("data_req_o", 0, data_req);
    check_value("busy_o", 0, busy);
    check_value("lsu_ready_ex_o", 1, lsu_ready_ex);
    check_value("lsu_ready_wb_o", 1, lsu_ready_wb);

    // narrow stores at every offset then word loads of the merged data
    for (int o = 0; o < 4; o++)
      do_access(1, lsu_pkg::ACC_BYTE, lsu_pkg::EXT_ZERO, 'h200 + o, $random(seed), $random(seed));
    for (int o = 0; o < 4; o++)
      do_access(1, lsu_pkg::ACC_HALF, lsu_pkg::EXT_ZERO, 'h210 + o, $random(seed), $random(seed));
    do_access(0, lsu_pkg::ACC_WORD, lsu_pkg::EXT_ZERO, 'h200, 0, 0);
    do_access(0, lsu_pkg::ACC_WORD, lsu_pkg::EXT_ZERO, 'h210, 0, 0);
    do_access(0, lsu_pkg::ACC_WORD, lsu_pkg::EXT_ZERO, 'h214, 0, 0); // upper byte of the split half

    // narrow loads at every offset and extension mode
    for (int e = 0; e < 3; e++)
      for (int o = 0; o < 4; o++)
      begin
        do_access(0, lsu_pkg::ACC_BYTE, lsu_pkg::ext_mode_e'(e), 'h120 + 16*e + o, 0, 0);
        do_access(0, lsu_pkg::ACC_HALF, lsu_pkg::ext_mode_e'(e), 'h160 + 16*e + o, 0, 0);
      end

    // split words
    for (int o = 1; o < 4; o++)
      do_access(0, lsu_pkg::ACC_WORD, lsu_pkg::EXT_ZERO, 'h1a0 + 8*o + o, 0, 0);

    // back-to-back mix with stores kept within a word
    for (int n = 0; n < 24; n++)
    begin
      t = lsu_pkg::access_type_e'($unsigned($random(seed)) % 3);
      a = 'h100 + 4 * ($unsigned($random(seed)) % 64) + ($unsigned($random(seed)) % 4);
      if (n % 2 == 0)
      begin
        if (t == lsu_pkg::ACC_WORD)
          a = a & ~3;
        else if (t == lsu_pkg::ACC_HALF && a[1:0] == 3)
          a = a - 1;
        do_access(1, t, lsu_pkg::EXT_ZERO, a, $random(seed), $random(seed));
      end
      else
        do_access(0, t, lsu_pkg::ext_mode_e'($unsigned($random(seed)) % 3), a, 0, 0);
    end

    @(posedge clk);
    data_req_ex        <= 1'b0;
    data_misaligned_ex <= 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
